// ==== sources.f ====
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/ex_mem_reg.sv
hdl/mem_stage.sv
hdl/data_mem.sv
hdl/mem_wb_stage.sv
hdl/mem_subsys.sv
bench/clk_gen.sv
bench/mem_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module mem_subsys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vmem_subsys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== bench/mem_subsys_tb.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module mem_subsys_tb;

    localparam int PREFILL_WORDS = 32;
    localparam int DIRECTED_MAX  = 100;
    localparam int RAND_COUNT    = 200;
    // a memory access plus one bubble per instruction, drains in the margin
    localparam int CYCLE_LIMIT =
        (PREFILL_WORDS + DIRECTED_MAX + RAND_COUNT) * (`DMEM_LATENCY + 3) + 500;
    localparam logic [6:0] NON_MEM_OPS [7] = '{rv32i_pkg::op_lui, rv32i_pkg::op_auipc,
        rv32i_pkg::op_jal, rv32i_pkg::op_jalr, rv32i_pkg::op_br, rv32i_pkg::op_imm,
        rv32i_pkg::op_reg};

    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [31:0] alu;
        logic [4:0]  rd;
    } stim_t;

    // expected retire record, due holds the retire cycle
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        trap;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic [31:0] due;
    } retire_t;

    logic               clk;
    logic               rst_n = 1'b0;
    logic               ex_valid = 1'b0;
    rv32i_pkg::opcode_t ex_opcode = rv32i_pkg::op_imm;
    logic [2:0]         ex_funct3 = 3'd0;
    logic [31:0]        ex_addr = 32'd0;
    logic [31:0]        ex_store_data = 32'd0;
    logic [31:0]        ex_alu_out = 32'd0;
    logic [4:0]         ex_rd = 5'd0;
    logic               ex_ready;
    logic               wb_valid;
    logic               wb_we;
    logic [4:0]         wb_rd;
    logic [31:0]        wb_data;
    logic               wb_trap;
    logic [31:0]        wb_mem_addr;
    logic [3:0]         wb_mem_rmask;
    logic [3:0]         wb_mem_wmask;
    logic [31:0]        wb_mem_wdata;

    stim_t      stim_q [$];
    retire_t    exp_q [$];
    string      name_q [$];
    logic [7:0] model_mem [4*`DMEM_WORDS];
    stim_t      drv_item;
    stim_t      acc_item;
    retire_t    exp_item;
    string      tname;
    string      cur_test = "reset";
    int         cyc = 0;
    int         value_errs = 0;
    int         other_errs = 0;
    logic       started = 1'b0;
    logic       bubbles = 1'b0;

    clk_gen #(.PERIOD(10)) u_clk_gen (.clk(clk));

    mem_subsys dut0 (.*);

    // fill value spread over the whole address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a3c_c3a5;
    endfunction

    // retire record from the access rules, stores update the model
    function automatic retire_t expect_record(input stim_t s);
        retire_t             r;
        logic                is_load;
        logic                is_store;
        logic                legal;
        logic [1:0]          off;
        int                  size;
        logic [`DMEM_AW+1:0] bidx;
        logic [31:0]         word;
        logic [31:0]         lane;
        r        = '0;
        r.rd     = s.rd;
        r.data   = s.alu;
        off      = s.addr[1:0];
        is_load  = s.opcode == rv32i_pkg::op_load;
        is_store = s.opcode == rv32i_pkg::op_store;
        // bytes per access from funct3[1:0]
        size  = 1 << s.funct3[1:0];
        legal = (s.funct3[1:0] != 2'b11) && (is_load ? s.funct3 != 3'b110 : !s.funct3[2]);
        if (is_load || is_store) begin
            r.addr = {s.addr[31:2], 2'b00};
            // halfwords on even bytes, words on offset 0
            r.trap = !legal || (int'(off) % size) != 0;
            if (!r.trap && is_load) r.rmask = 4'(((1 << size) - 1) << off);
            if (!r.trap && is_store) r.wmask = 4'(((1 << size) - 1) << off);
        end
        bidx = {s.addr[`DMEM_AW+1:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            bidx[1:0]      = 2'(i);
            word[8*i +: 8] = model_mem[bidx];
        end
        lane = word >> (8 * off);
        if (r.rmask != 4'd0) begin
            case (s.funct3)
                3'b000:  r.data = {{24{lane[7]}}, lane[7:0]};
                3'b100:  r.data = {24'd0, lane[7:0]};
                3'b001:  r.data = {{16{lane[15]}}, lane[15:0]};
                3'b101:  r.data = {16'd0, lane[15:0]};
                default: r.data = word;
            endcase
        end
        if (r.wmask != 4'd0) begin
            r.wdata = s.sdata << (8 * off);
            for (int i = 0; i < 4; i++) begin
                bidx[1:0] = 2'(i);
                if (r.wmask[i]) model_mem[bidx] = r.wdata[8*i +: 8];
            end
        end
        r.we  = !r.trap && !is_store && s.opcode != rv32i_pkg::op_br && s.rd != 5'd0;
        // only clean accesses wait for the memory
        r.due = (r.rmask != 4'd0 || r.wmask != 4'd0) ? 32'(`DMEM_LATENCY + 2) : 32'd2;
        return r;
    endfunction

    function automatic logic [6:0] pick_op();
        case ($urandom_range(0, 7))
            0, 1, 2: return rv32i_pkg::op_load;
            3, 4, 5: return rv32i_pkg::op_store;
            default: return NON_MEM_OPS[3'($urandom_range(0, 6))];
        endcase
    endfunction

    task automatic push_instr(input logic [6:0] op, input logic [2:0] f3,
                              input logic [31:0] a, input logic [31:0] sdata,
                              input logic [31:0] alu, input logic [4:0] rd);
        stim_q.push_back({op, f3, a, sdata, alu, rd});
    endtask

    // until all pushed instructions have retired
    task automatic drain();
        while (stim_q.size() != 0 || exp_q.size() != 0 || ex_valid) @(negedge clk);
    endtask

    task automatic check_val(input string test, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            value_errs++;
            $display("Error %s: %s expected %h, actual %h", test, field, exp_v, act_v);
        end
    endtask

    // driver, holds the instruction while ex_ready is low
    always @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (!ex_valid || ex_ready) begin
            if (stim_q.size() != 0 && !(bubbles && $urandom_range(0, 3) == 0)) begin
                drv_item = stim_q.pop_front();
                ex_valid      <= 1'b1;
                ex_opcode     <= rv32i_pkg::opcode_t'(drv_item.opcode);
                ex_funct3     <= drv_item.funct3;
                ex_addr       <= drv_item.addr;
                ex_store_data <= drv_item.sdata;
                ex_alu_out    <= drv_item.alu;
                ex_rd         <= drv_item.rd;
            end else begin
                ex_valid <= 1'b0;
            end
        end
    end

    // monitor, all values sampled before the edge updates them
    always @(posedge clk) begin
        if (rst_n) begin
            if (!started) begin
                assert (!wb_valid && ex_ready) else begin
                    other_errs++;
                    $display("reset: wb_valid high or ex_ready low before the first instruction");
                end
            end
            if (ex_valid && ex_ready) begin
                started  = 1'b1;
                acc_item = {ex_opcode, ex_funct3, ex_addr, ex_store_data, ex_alu_out, ex_rd};
                exp_item = expect_record(acc_item);
                exp_item.due = exp_item.due + 32'(cyc);
                exp_q.push_back(exp_item);
                name_q.push_back(cur_test);
            end
            if (wb_valid) begin
                assert (exp_q.size() != 0) else begin
                    other_errs++;
                    $display("retire at cycle %0d with no instruction outstanding", cyc);
                end
                if (exp_q.size() != 0) begin
                    exp_item = exp_q.pop_front();
                    tname    = name_q.pop_front();
                    check_val(tname, "wb_we", 32'(exp_item.we), 32'(wb_we));
                    check_val(tname, "wb_rd", 32'(exp_item.rd), 32'(wb_rd));
                    check_val(tname, "wb_data", exp_item.data, wb_data);
                    check_val(tname, "wb_trap", 32'(exp_item.trap), 32'(wb_trap));
                    check_val(tname, "wb_mem_addr", exp_item.addr, wb_mem_addr);
                    check_val(tname, "wb_mem_rmask", 32'(exp_item.rmask), 32'(wb_mem_rmask));
                    check_val(tname, "wb_mem_wmask", 32'(exp_item.wmask), 32'(wb_mem_wmask));
                    check_val(tname, "wb_mem_wdata", exp_item.wdata, wb_mem_wdata);
                    check_val(tname, "retire cycle", exp_item.due, 32'(cyc));
                end
            end
        end
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [6:0]  op;
        logic [2:0]  f3;
        int          k;
        void'($urandom(93));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);

        // known contents for every word that later loads touch
        cur_test = "prefill";
        for (int i = 0; i < PREFILL_WORDS; i++) begin
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sw, 32'(4 * i), fill_word(32'(4 * i)),
                       $urandom(), 5'd0);
        end
        drain();

        // partial stores merged into one word, then read back
        cur_test = "store_merge";
        for (int w = 4; w < 7; w++) begin
            a = 32'(4 * w);
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sw, a, $urandom(), $urandom(), 5'd0);
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sh, a + ($urandom() & 32'd2),
                       $urandom(), $urandom(), 5'd1);
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sb, a + 32'($urandom_range(0, 3)),
                       $urandom(), $urandom(), 5'd2);
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sb, a + 32'd3, $urandom(), $urandom(), 5'd3);
            push_instr(rv32i_pkg::op_load, rv32i_pkg::lw, a, $urandom(), $urandom(), 5'(w));
        end
        // one word built from four bytes
        for (int i = 0; i < 4; i++) begin
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sb, 32'h40 + 32'(i), $urandom(),
                       $urandom(), 5'd0);
        end
        push_instr(rv32i_pkg::op_load, rv32i_pkg::lw, 32'h40, $urandom(), $urandom(), 5'd9);
        drain();

        // byte and halfword loads at every legal offset
        cur_test = "load_ext";
        for (int w = 8; w < 10; w++) begin
            a = 32'(4 * w);
            push_instr(rv32i_pkg::op_store, rv32i_pkg::sw, a, (w == 8) ? 32'h80ff_7f01 : $urandom(),
                       $urandom(), 5'd0);
            for (int i = 0; i < 4; i++) begin
                push_instr(rv32i_pkg::op_load, rv32i_pkg::lb, a + 32'(i), $urandom(), $urandom(),
                           5'($urandom_range(1, 31)));
                push_instr(rv32i_pkg::op_load, rv32i_pkg::lbu, a + 32'(i), $urandom(), $urandom(),
                           5'($urandom_range(1, 31)));
                if (i % 2 == 0) begin
                    push_instr(rv32i_pkg::op_load, rv32i_pkg::lh, a + 32'(i), $urandom(),
                               $urandom(), 5'($urandom_range(1, 31)));
                    push_instr(rv32i_pkg::op_load, rv32i_pkg::lhu, a + 32'(i), $urandom(),
                               $urandom(), 5'($urandom_range(1, 31)));
                end
            end
        end
        drain();

        // each non-memory opcode alone, then back to back
        cur_test = "non_mem";
        for (int i = 0; i < 7; i++) begin
            push_instr(NON_MEM_OPS[3'(i)], 3'($urandom_range(0, 7)), $urandom(), $urandom(),
                       $urandom(), 5'(i + 1));
            drain();
        end
        for (int i = 0; i < 7; i++) begin
            push_instr(NON_MEM_OPS[3'(i)], 3'($urandom_range(0, 7)), $urandom(), $urandom(),
                       $urandom(), 5'((i == 6) ? 0 : i + 3));
        end
        drain();

        // misaligned accesses trap, the closing lw sees the word untouched
        cur_test = "misaligned";
        a = 32'h30;
        push_instr(rv32i_pkg::op_store, rv32i_pkg::sw, a, 32'hc0de_5a17, $urandom(), 5'd0);
        push_instr(rv32i_pkg::op_load, rv32i_pkg::lh, a + 32'd1, $urandom(), $urandom(), 5'd4);
        push_instr(rv32i_pkg::op_load, rv32i_pkg::lhu, a + 32'd3, $urandom(), $urandom(), 5'd5);
        push_instr(rv32i_pkg::op_load, rv32i_pkg::lw, a + 32'd2, $urandom(), $urandom(), 5'd6);
        push_instr(rv32i_pkg::op_store, rv32i_pkg::sh, a + 32'd1, $urandom(), $urandom(), 5'd7);
        push_instr(rv32i_pkg::op_store, rv32i_pkg::sw, a + 32'd3, $urandom(), $urandom(), 5'd8);
        push_instr(rv32i_pkg::op_load, rv32i_pkg::lw, a, $urandom(), $urandom(), 5'd10);
        drain();

        // mixed stream with random input bubbles
        cur_test = "random";
        bubbles  = 1'b1;
        for (int n = 0; n < RAND_COUNT; n++) begin
            op = pick_op();
            k  = int'($urandom_range(0, 4));
            if (op == rv32i_pkg::op_load) f3 = (k > 2) ? 3'(k + 1) : 3'(k);
            else if (op == rv32i_pkg::op_store) f3 = 3'($urandom_range(0, 2));
            else f3 = 3'($urandom_range(0, 7));
            // random upper bits alias onto the filled words 0 to 31
            a = {22'($urandom()), 3'b000, 5'($urandom_range(0, 31)), 2'($urandom_range(0, 3))};
            push_instr(op, f3, a, $urandom(), $urandom(), 5'($urandom_range(0, 31)));
        end
        drain();
        bubbles = 1'b0;
        repeat (4) @(negedge clk);

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

// free-running clock for the testbench
module clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    // starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_subsys.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module mem_subsys (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  rv32i_pkg::opcode_t    ex_opcode,
    input  logic [2:0]            ex_funct3,
    input  logic [`XLEN-1:0]      ex_addr,
    input  logic [`XLEN-1:0]      ex_store_data,
    input  logic [`XLEN-1:0]      ex_alu_out,
    input  logic [4:0]            ex_rd,
    output logic                  ex_ready,
    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [4:0]            wb_rd,
    output logic [`XLEN-1:0]      wb_data,
    output logic                  wb_trap,
    output logic [`XLEN-1:0]      wb_mem_addr,
    output logic [3:0]            wb_mem_rmask,
    output logic [3:0]            wb_mem_wmask,
    output logic [`XLEN-1:0]      wb_mem_wdata
);

    // EX/MEM contents
    logic               mm_valid;
    rv32i_pkg::opcode_t mm_opcode;
    logic [2:0]         mm_funct3;
    logic [`XLEN-1:0]   mm_addr;
    logic [`XLEN-1:0]   mm_store_data;
    logic [`XLEN-1:0]   mm_alu_out;
    logic [4:0]         mm_rd;
    logic               mem_stall;

    // data memory bus
    logic [`XLEN-1:0]   dmem_address;
    logic               dmem_read;
    logic               dmem_write;
    logic [`XLEN-1:0]   dmem_wdata;
    logic [3:0]         dmem_byte_enable;
    logic [`XLEN-1:0]   dmem_rdata;
    logic               dmem_resp;

    // stage output toward MEM/WB
    logic               st_done;
    logic               st_trap;
    logic [3:0]         st_rmask;
    logic [3:0]         st_wmask;
    logic [`XLEN-1:0]   st_mem_addr;
    logic [`XLEN-1:0]   st_mem_wdata;
    rv32i_pkg::opcode_t st_opcode;
    logic [2:0]         st_funct3;
    logic [1:0]         st_addr_lo;
    logic [`XLEN-1:0]   st_alu_out;
    logic [4:0]         st_rd;
    logic [`XLEN-1:0]   st_load_word;

    ex_mem_reg u_ex_mem (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_opcode(ex_opcode),
        .ex_funct3(ex_funct3), .ex_addr(ex_addr), .ex_store_data(ex_store_data),
        .ex_alu_out(ex_alu_out), .ex_rd(ex_rd), .mem_stall(mem_stall),
        .ex_ready(ex_ready), .mm_valid(mm_valid), .mm_opcode(mm_opcode),
        .mm_funct3(mm_funct3), .mm_addr(mm_addr), .mm_store_data(mm_store_data),
        .mm_alu_out(mm_alu_out), .mm_rd(mm_rd)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst_n(rst_n), .mm_valid(mm_valid), .mm_opcode(mm_opcode),
        .mm_funct3(mm_funct3), .mm_addr(mm_addr), .mm_store_data(mm_store_data),
        .mm_alu_out(mm_alu_out), .mm_rd(mm_rd), .dmem_rdata(dmem_rdata),
        .dmem_resp(dmem_resp), .mem_stall(mem_stall), .dmem_address(dmem_address),
        .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_wdata(dmem_wdata),
        .dmem_byte_enable(dmem_byte_enable), .st_done(st_done), .st_trap(st_trap),
        .st_rmask(st_rmask), .st_wmask(st_wmask), .st_mem_addr(st_mem_addr),
        .st_mem_wdata(st_mem_wdata), .st_opcode(st_opcode), .st_funct3(st_funct3),
        .st_addr_lo(st_addr_lo), .st_alu_out(st_alu_out), .st_rd(st_rd),
        .st_load_word(st_load_word)
    );

    data_mem u_data_mem (
        .clk(clk), .rst_n(rst_n), .dmem_address(dmem_address),
        .dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_wdata(dmem_wdata),
        .dmem_byte_enable(dmem_byte_enable), .dmem_rdata(dmem_rdata),
        .dmem_resp(dmem_resp)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk), .rst_n(rst_n), .st_done(st_done), .st_trap(st_trap),
        .st_rmask(st_rmask), .st_wmask(st_wmask), .st_mem_addr(st_mem_addr),
        .st_mem_wdata(st_mem_wdata), .st_opcode(st_opcode), .st_funct3(st_funct3),
        .st_addr_lo(st_addr_lo), .st_alu_out(st_alu_out), .st_rd(st_rd),
        .st_load_word(st_load_word), .wb_valid(wb_valid), .wb_we(wb_we),
        .wb_rd(wb_rd), .wb_data(wb_data), .wb_trap(wb_trap),
        .wb_mem_addr(wb_mem_addr), .wb_mem_rmask(wb_mem_rmask),
        .wb_mem_wmask(wb_mem_wmask), .wb_mem_wdata(wb_mem_wdata)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module mem_wb_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  st_done,
    input  logic                  st_trap,
    input  logic [3:0]            st_rmask,
    input  logic [3:0]            st_wmask,
    input  logic [`XLEN-1:0]      st_mem_addr,
    input  logic [`XLEN-1:0]      st_mem_wdata,
    input  rv32i_pkg::opcode_t    st_opcode,
    input  logic [2:0]            st_funct3,
    input  logic [1:0]            st_addr_lo,
    input  logic [`XLEN-1:0]      st_alu_out,
    input  logic [4:0]            st_rd,
    input  logic [`XLEN-1:0]      st_load_word,
    output logic                  wb_valid,
    output logic                  wb_we,
    output logic [4:0]            wb_rd,
    output logic [`XLEN-1:0]      wb_data,
    output logic                  wb_trap,
    output logic [`XLEN-1:0]      wb_mem_addr,
    output logic [3:0]            wb_mem_rmask,
    output logic [3:0]            wb_mem_wmask,
    output logic [`XLEN-1:0]      wb_mem_wdata
);

    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;
    logic [`XLEN-1:0] load_val;
    logic [`XLEN-1:0] data_next;
    logic             we_next;

    // byte and halfword picked by offset
    assign ld_byte = st_load_word[{st_addr_lo, 3'b000} +: 8];
    assign ld_half = st_load_word[{st_addr_lo[1], 4'b0000} +: 16];

    // sign or zero extension by funct3
    always_comb begin
        case (rv32i_pkg::load_funct3_t'(st_funct3))
            rv32i_pkg::lb:  load_val = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            rv32i_pkg::lbu: load_val = {{(`XLEN-8){1'b0}}, ld_byte};
            rv32i_pkg::lh:  load_val = {{(`XLEN-16){ld_half[15]}}, ld_half};
            rv32i_pkg::lhu: load_val = {{(`XLEN-16){1'b0}}, ld_half};
            default:        load_val = st_load_word;
        endcase
    end

    // trapped loads fall back to alu_out, we is low anyway
    assign data_next = (st_opcode == rv32i_pkg::op_load && !st_trap) ? load_val : st_alu_out;

    // no register write for stores, branches, traps or x0
    assign we_next = !st_trap
                  && st_opcode != rv32i_pkg::op_store
                  && st_opcode != rv32i_pkg::op_br
                  && st_rd != 5'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= st_done;
        end
    end

    // retire record, held between instructions
    always_ff @(posedge clk) begin
        if (st_done) begin
            wb_we        <= we_next;
            wb_rd        <= st_rd;
            wb_data      <= data_next;
            wb_trap      <= st_trap;
            wb_mem_addr  <= st_mem_addr;
            wb_mem_rmask <= st_rmask;
            wb_mem_wmask <= st_wmask;
            wb_mem_wdata <= st_mem_wdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/data_mem.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module data_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`XLEN-1:0]      dmem_address,
    input  logic                  dmem_read,
    input  logic                  dmem_write,
    input  logic [`XLEN-1:0]      dmem_wdata,
    input  logic [3:0]            dmem_byte_enable,
    output logic [`XLEN-1:0]      dmem_rdata,
    output logic                  dmem_resp
);

    localparam int CW = $clog2(`DMEM_LATENCY + 1);

    logic [`XLEN-1:0]    mem [`DMEM_WORDS];
    logic [`DMEM_AW-1:0] idx;
    logic [CW-1:0]       cnt;
    logic                req;
    logic                fire;

    // word index sits above the byte offset
    assign idx = dmem_address[`DMEM_AW+1:2];
    assign req = dmem_read || dmem_write;

    // last waiting cycle, resp rises on the next edge
    // the resp cycle itself is never counted as a new request
    assign fire = req && !dmem_resp && (cnt == CW'(`DMEM_LATENCY - 1));

    // latency counter and response pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            dmem_resp <= 1'b0;
        end else begin
            dmem_resp <= fire;
            if (fire) begin
                cnt <= '0;
            end else if (req && !dmem_resp) begin
                cnt <= cnt + CW'(1);
            end
        end
    end

    // array access on the response edge
    always_ff @(posedge clk) begin
        if (fire && dmem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_byte_enable[i]) begin
                    mem[idx][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
        if (fire && dmem_read) begin
            dmem_rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module mem_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mm_valid,
    input  rv32i_pkg::opcode_t    mm_opcode,
    input  logic [2:0]            mm_funct3,
    input  logic [`XLEN-1:0]      mm_addr,
    input  logic [`XLEN-1:0]      mm_store_data,
    input  logic [`XLEN-1:0]      mm_alu_out,
    input  logic [4:0]            mm_rd,
    input  logic [`XLEN-1:0]      dmem_rdata,
    input  logic                  dmem_resp,
    output logic                  mem_stall,
    output logic [`XLEN-1:0]      dmem_address,
    output logic                  dmem_read,
    output logic                  dmem_write,
    output logic [`XLEN-1:0]      dmem_wdata,
    output logic [3:0]            dmem_byte_enable,
    output logic                  st_done,
    output logic                  st_trap,
    output logic [3:0]            st_rmask,
    output logic [3:0]            st_wmask,
    output logic [`XLEN-1:0]      st_mem_addr,
    output logic [`XLEN-1:0]      st_mem_wdata,
    output rv32i_pkg::opcode_t    st_opcode,
    output logic [2:0]            st_funct3,
    output logic [1:0]            st_addr_lo,
    output logic [`XLEN-1:0]      st_alu_out,
    output logic [4:0]            st_rd,
    output logic [`XLEN-1:0]      st_load_word
);

    rv32i_pkg::mem_state_t state, state_next;

    logic       is_load;
    logic       is_store;
    logic       misaligned;
    logic       illegal;
    logic       access;
    logic       resp_ok;
    logic [1:0] off;
    logic [3:0] rmask;
    logic [3:0] wmask;

    assign is_load  = mm_opcode == rv32i_pkg::op_load;
    assign is_store = mm_opcode == rv32i_pkg::op_store;
    assign off      = mm_addr[1:0];

    // word aligned address, byte lanes picked by the masks
    assign dmem_address = {mm_addr[`XLEN-1:2], 2'b00};

    // store data moved into its byte lane
    // sh only reaches offsets 0 and 2, sw only 0
    assign dmem_wdata = mm_store_data << {off, 3'b000};

    // masks and alignment check
    always_comb begin
        rmask      = 4'b0000;
        wmask      = 4'b0000;
        misaligned = 1'b0;
        illegal    = 1'b0;
        if (is_load) begin
            case (rv32i_pkg::load_funct3_t'(mm_funct3))
                rv32i_pkg::lb, rv32i_pkg::lbu: rmask = 4'b0001 << off;
                rv32i_pkg::lh, rv32i_pkg::lhu: begin
                    rmask      = 4'b0011 << off;
                    misaligned = off[0];
                end
                rv32i_pkg::lw: begin
                    rmask      = 4'b1111;
                    misaligned = |off;
                end
                default: illegal = 1'b1;
            endcase
        end else if (is_store) begin
            case (rv32i_pkg::store_funct3_t'(mm_funct3))
                rv32i_pkg::sb: wmask = 4'b0001 << off;
                rv32i_pkg::sh: begin
                    wmask      = 4'b0011 << off;
                    misaligned = off[0];
                end
                rv32i_pkg::sw: begin
                    wmask      = 4'b1111;
                    misaligned = |off;
                end
                default: illegal = 1'b1;
            endcase
        end
        // a trapped access touches no bytes
        if (misaligned || illegal) begin
            rmask = 4'b0000;
            wmask = 4'b0000;
        end
    end

    // only clean loads and stores go to memory
    assign access = mm_valid && (is_load || is_store) && !misaligned && !illegal;

    // request control
    always_comb begin
        state_next = state;
        case (state)
            rv32i_pkg::s_idle: if (access) state_next = rv32i_pkg::s_wait;
            rv32i_pkg::s_wait: if (dmem_resp) state_next = rv32i_pkg::s_idle;
            default: state_next = rv32i_pkg::s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv32i_pkg::s_idle;
        end else begin
            state <= state_next;
        end
    end

    // a response only counts once a request is outstanding
    assign resp_ok = (state == rv32i_pkg::s_wait) && dmem_resp;

    // request held from the first cycle up to and including resp
    assign dmem_read        = access && is_load;
    assign dmem_write       = access && is_store;
    assign dmem_byte_enable = rmask | wmask;
    assign mem_stall        = access && !resp_ok;

    // leaving record for MEM/WB
    assign st_done      = mm_valid && !mem_stall;
    assign st_trap      = misaligned || illegal;
    assign st_rmask     = rmask;
    assign st_wmask     = wmask;
    assign st_mem_addr  = (is_load || is_store) ? dmem_address : '0;
    assign st_mem_wdata = (wmask != 4'b0000) ? dmem_wdata : '0;
    assign st_opcode    = mm_opcode;
    assign st_funct3    = mm_funct3;
    assign st_addr_lo   = off;
    assign st_alu_out   = mm_alu_out;
    assign st_rd        = mm_rd;
    // word is valid in the resp cycle, MEM/WB takes it on that edge
    assign st_load_word = dmem_rdata;

endmodule

`default_nettype wire

// ==== hdl/ex_mem_reg.sv ====
`default_nettype none

`include "rv32i_defs.svh"

module ex_mem_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  rv32i_pkg::opcode_t    ex_opcode,
    input  logic [2:0]            ex_funct3,
    input  logic [`XLEN-1:0]      ex_addr,
    input  logic [`XLEN-1:0]      ex_store_data,
    input  logic [`XLEN-1:0]      ex_alu_out,
    input  logic [4:0]            ex_rd,
    input  logic                  mem_stall,
    output logic                  ex_ready,
    output logic                  mm_valid,
    output rv32i_pkg::opcode_t    mm_opcode,
    output logic [2:0]            mm_funct3,
    output logic [`XLEN-1:0]      mm_addr,
    output logic [`XLEN-1:0]      mm_store_data,
    output logic [`XLEN-1:0]      mm_alu_out,
    output logic [4:0]            mm_rd
);

    logic accept;

    // free slot, or the current one leaves this cycle
    // combinational so the producer sees the stall at once
    assign ex_ready = !mm_valid || !mem_stall;
    assign accept   = ex_valid && ex_ready;

    // valid bit, cleared to empty when nothing new arrives
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_valid <= 1'b0;
        end else if (ex_ready) begin
            mm_valid <= ex_valid;
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            mm_opcode     <= ex_opcode;
            mm_funct3     <= ex_funct3;
            mm_addr       <= ex_addr;
            mm_store_data <= ex_store_data;
            mm_alu_out    <= ex_alu_out;
            mm_rd         <= ex_rd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // rv32i major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    // funct3 of loads
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    // funct3 of stores
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // request control of the memory stage
    typedef enum logic {
        s_idle = 1'b0,
        s_wait = 1'b1
    } mem_state_t;

endpackage

`default_nettype wire

// ==== hdl/rv32i_defs.svh ====
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// data and address width
`define XLEN 32

// data memory depth in 32-bit words
`define DMEM_WORDS 256

// word index width, log2 of the depth
`define DMEM_AW 8

// cycles from first sight of a request to dmem_resp
// any value of 1 or more is fine
`define DMEM_LATENCY 2

`endif
